/* Bender.yml */
package:
  name: nocOutPort

sources:
  - src/nocArbPkg.sv
  - src/flitChannel.sv
  - src/holdTimerBank.sv
  - src/grantFsm.sv
  - src/flitSwitch.sv
  - src/nocOutPort.sv
  - target: test
    files:
      - dv/arbRefModel.sv
      - dv/tbNocOutPort.sv

/* dv/arbRefModel.sv */
package arbRefModel;

  import nocArbPkg::*;

  // Registered state of the output port
  typedef struct packed {
    chanMaskT        grant;
    lenT [NumCh-1:0] lenReg;
    lenT [NumCh-1:0] count;
  } arbStateT;

  // Channel number of the holder, -1 when idle
  function automatic int ownerOf(input chanMaskT g);
    int o;
    o = -1;
    for (int c = 0; c < NumCh; c++)
    begin
      if (g[c])
      begin
        o = c;
      end
    end
    return o;
  endfunction

  // Walk L N E W S starting one past holder
  function automatic chanMaskT nextInRing(input chanMaskT reqs, input int holder);
    chanMaskT pick;
    int       c;
    pick = '0;
    c    = holder;
    for (int k = 0; k < NumCh; k++)
    begin
      c = (c + 1) % NumCh;
      if (reqs[c])
      begin
        pick[c] = 1'b1;
        break;
      end
    end
    return pick;
  endfunction

  // One clock edge of timers and grant together
  function automatic arbStateT stepArb(
    input arbStateT s,
    input chanMaskT req,
    input flitIdT   ids  [NumCh],
    input lenT      lens [NumCh]
  );
    arbStateT n;
    chanMaskT run;
    int       owner;
    n     = s;
    run   = '0;
    owner = ownerOf(s.grant);
    if (owner < 0)
    begin
      n.grant = nextInRing(req, NumCh - 1); // Idle starts at L
    end
    else if (req[owner] && s.count[owner] != s.lenReg[owner])
    begin
      run[owner] = 1'b1;
    end
    else
    begin
      n.grant = nextInRing(req & ~s.grant, owner);
    end
    for (int c = 0; c < NumCh; c++)
    begin
      if (ids[c] == FlitHead)
      begin
        n.lenReg[c] = lens[c];
      end
      n.count[c] = run[c] ? s.count[c] + 1'b1 : '0;
    end
    return n;
  endfunction

endpackage

/* dv/tbNocOutPort.sv */
`timescale 1ns/100ps

module tbNocOutPort;

  import nocArbPkg::*;
  import arbRefModel::*;

  localparam int Seed       = 37961;
  localparam int RandCycles = 3000;
  localparam int DirCycles  = 80;
  localparam int TimeoutNs  = (RandCycles + DirCycles) * 10 + 500;

  logic     clk;
  logic     rst;
  chanMaskT req;
  flitIdT   flitId [NumCh];
  lenT      length [NumCh];
  dataT     data   [NumCh];
  chanMaskT grant;
  flitIdT   outFlitId;
  dataT     outData;
  logic     outValid;

  arbStateT model;
  int       errors;
  int       checks;

  nocOutPort u_dut (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .flitId    (flitId),
    .length    (length),
    .data      (data),
    .grant     (grant),
    .outFlitId (outFlitId),
    .outData   (outData),
    .outValid  (outValid)
  );

  always #5 clk = ~clk;

  task automatic checkValue(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
    checks++;
    assert (expVal === actVal) else
    begin
      $display("[FAIL] %s expected %h got %h at %0t", name, expVal, actVal, $time);
      errors++;
    end
  endtask

  task automatic compareOutputs();
    int   owner;
    logic expValid;
    owner    = ownerOf(model.grant);
    expValid = 1'b0; // Idle port has no valid
    if (owner >= 0)
    begin
      expValid = req[owner];
    end
    checkValue("grant", model.grant, grant);
    checkValue("outValid", expValid, outValid);
    if (owner >= 0)
    begin
      checkValue("outFlitId", flitId[owner], outFlitId);
      checkValue("outData", data[owner], outData);
    end
  endtask

  // Compare at the falling edge and step the model on the rising edge
  task automatic runCycle();
    @(negedge clk);
    compareOutputs();
    @(posedge clk);
    model = stepArb(model, req, flitId, length);
    #1;
  endtask

  task automatic driveAll(input chanMaskT r, input flitIdT id, input lenT len);
    req = r;
    for (int c = 0; c < NumCh; c++)
    begin
      flitId[c] = id;
      length[c] = len;
      data[c]   = $urandom;
    end
  endtask

  task automatic driveRandom();
    for (int c = 0; c < NumCh; c++)
    begin
      if (flitId[c] == FlitTail || (req[c] && $urandom % 16 == 0))
      begin
        req[c]    = 1'b0; // Packet done or source stalls
        flitId[c] = FlitBody;
      end
      else if (!req[c])
      begin
        if ($urandom % 4 != 0)
        begin
          req[c]    = 1'b1;
          flitId[c] = FlitHead;
          length[c] = lenT'($urandom % 7);
        end
      end
      else
      begin
        flitId[c] = ($urandom % 8 == 0) ? FlitTail : FlitBody;
      end
      data[c] = $urandom;
    end
  endtask

  initial
  begin
    int held;
    void'($urandom(Seed));
    errors = 0;
    checks = 0;
    clk    = 1'b0;
    rst    = 1'b1;
    model  = '0;
    driveAll('0, FlitBody, '0);
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // Zero-length packets on every channel
    for (int k = 0; k < 11; k++)
    begin
      driveAll('1, FlitHead, '0);
      runCycle();
      checkValue("grant", chanMaskT'(1) << (k % NumCh), grant);
    end

    driveAll('0, FlitBody, '0);
    runCycle();
    runCycle();
    driveAll(5'b00100, FlitHead, lenT'(3)); // East alone with length 3
    runCycle();
    driveAll(5'b00100, FlitBody, '0);
    held = 0;
    while (grant == 5'b00100 && held < 20)
    begin
      held++;
      runCycle();
    end
    checkValue("holdCycles", 4, held);
    checkValue("grant", '0, grant);
    runCycle();
    checkValue("grant", 5'b00100, grant);

    // Holder drops its request
    driveAll('0, FlitBody, '0);
    runCycle();
    runCycle();
    driveAll(5'b10101, FlitHead, lenT'(5));
    runCycle();
    driveAll(5'b10101, FlitBody, '0);
    runCycle();
    checkValue("grant", 5'b00001, grant);
    driveAll(5'b10100, FlitBody, '0);
    runCycle();
    checkValue("grant", 5'b00100, grant);
    driveAll(5'b10000, FlitBody, '0);
    runCycle();
    checkValue("grant", 5'b10000, grant);
    driveAll('0, FlitBody, '0);
    runCycle();
    checkValue("grant", '0, grant);

    for (int k = 0; k < RandCycles; k++)
    begin
      driveRandom();
      runCycle();
    end

    $display("Summary: %0d errors in %0d checks", errors, checks);
    if (errors == 0)
    begin
      $display("ALL TESTS PASSED");
    end
    else
    begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial
  begin
    #(TimeoutNs);
    $display("Watchdog: run did not finish within %0d ns, %0d errors so far", TimeoutNs,
             errors);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* nocOutPort.f */
src/nocArbPkg.sv
src/flitChannel.sv
src/holdTimerBank.sv
src/grantFsm.sv
src/flitSwitch.sv
src/nocOutPort.sv
dv/arbRefModel.sv
dv/tbNocOutPort.sv

/* src/flitChannel.sv */
`timescale 1ns/100ps

interface flitChannel (
  input logic clk
);

  import nocArbPkg::*;

  chanMaskT req;             // Request level per channel
  flitIdT   flitId [NumCh];
  lenT      length [NumCh];  // Valid with a head flit
  dataT     data   [NumCh];

  modport src (
    output req, flitId, length, data
  );

  modport timer (
    input flitId, length
  );

  modport arb (
    input req
  );

  // Clock is only for checks in the switch
  modport sw (
    input clk, req, flitId, data
  );

endinterface

/* src/flitSwitch.sv */
`timescale 1ns/100ps

module flitSwitch #(
  parameter type payloadT = nocArbPkg::flitT
) (
  flitChannel.sw              ch,
  input  nocArbPkg::chanMaskT grant,
  output payloadT             outFlit,
  output logic                outValid
);

  import nocArbPkg::*;

  payloadT                    chanFlit [NumCh]; // Id and data per channel
  logic [$bits(payloadT)-1:0] selBits;

  for (genvar g = 0; g < NumCh; g++)
  begin : genPack
    assign chanFlit[g] = payloadT'({ch.flitId[g], ch.data[g]});
  end

  // AND-OR select over the one-hot grant
  always_comb
  begin
    selBits = '0;
    for (int i = 0; i < NumCh; i++)
    begin
      selBits = selBits | ({$bits(payloadT){grant[i]}} & chanFlit[i]);
    end
  end

  assign outFlit  = payloadT'(selBits);
  assign outValid = |(grant & ch.req); // Granted request level

  // Valid output means exactly one channel owns the port
  property validOwned;
    @(posedge ch.clk)
      outValid |-> $onehot(grant);
  endproperty
  assert property (validOwned)
    else $error("outValid with grant %h", grant);

endmodule

/* src/grantFsm.sv */
`timescale 1ns/100ps

module grantFsm (
  input  logic                clk,
  input  logic                rst,
  flitChannel.arb             ch,
  input  nocArbPkg::chanMaskT timesUp,
  output nocArbPkg::chanMaskT run,
  output nocArbPkg::chanMaskT grant
);

  import nocArbPkg::*;

  chanMaskT nextGrant;
  chanMaskT holdMask;  // Holder still requesting and not expired
  chanIdxT  curIdx;    // Position of the current holder

  // First requester at or after position first, wrapping around
  function automatic chanMaskT rotatePick(
    input chanMaskT reqs,
    input int       first
  );
    chanMaskT pick;
    int       idx;
    pick = '0;
    for (int k = 0; k < NumCh; k++)
    begin
      idx = (first + k) % NumCh;
      if (pick == '0 && reqs[idx])
      begin
        pick[idx] = 1'b1;
      end
    end
    return pick;
  endfunction

  // Index of the one-hot grant
  always_comb
  begin
    curIdx = '0;
    for (int i = 0; i < NumCh; i++)
    begin
      if (grant[i])
      begin
        curIdx = chanIdxT'(i);
      end
    end
  end

  assign holdMask = grant & ch.req & ~timesUp;

  always_comb
  begin
    run       = '0;
    nextGrant = '0;
    if (grant == '0)
    begin
      nextGrant = rotatePick(ch.req, 0); // Idle scans from L
    end
    else if (holdMask != '0)
    begin
      run       = holdMask;
      nextGrant = grant; // Tenure continues
    end
    else
    begin
      // Released: rotate past the holder, never back to it
      nextGrant = rotatePick(ch.req & ~grant, int'(curIdx) + 1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= '0;
    end
    else
    begin
      grant <= nextGrant;
    end
  end

  property grantOneHot;
    @(posedge clk) disable iff (rst)
      $onehot0(grant);
  endproperty
  assert property (grantOneHot)
    else $error("grant not one-hot: %h", grant);

  property runInGrant;
    @(posedge clk) disable iff (rst)
      (run & ~grant) == '0;
  endproperty
  assert property (runInGrant)
    else $error("run %h outside grant %h", run, grant);

  // A new grant only lands on a channel that asked in the prior cycle
  property grantFollowsReq;
    @(posedge clk) disable iff (rst)
      !$past(rst) |-> (grant & ~$past(ch.req)) == '0;
  endproperty
  assert property (grantFollowsReq)
    else $error("grant %h to a channel without request", grant);

endmodule

/* src/holdTimerBank.sv */
`timescale 1ns/100ps

module holdTimerBank (
  input  logic               clk,
  input  logic               rst,
  flitChannel.timer          ch,
  input  nocArbPkg::chanMaskT run,
  output nocArbPkg::chanMaskT timesUp
);

  import nocArbPkg::*;

  lenT lenReg [NumCh]; // Latched packet length
  lenT count  [NumCh]; // Cycles held so far

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < NumCh; i++)
      begin
        lenReg[i] <= '0;
        count[i]  <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < NumCh; i++)
      begin
        if (ch.flitId[i] == FlitHead)
        begin
          lenReg[i] <= ch.length[i]; // Header carries the length
        end
        if (run[i])
        begin
          count[i] <= count[i] + 1'b1;
        end
        else
        begin
          count[i] <= '0; // Idle or not holding
        end
      end
    end
  end

  always_comb
  begin
    for (int i = 0; i < NumCh; i++)
    begin
      timesUp[i] = (count[i] == lenReg[i]);
    end
  end

  // A running counter stays below its length
  for (genvar g = 0; g < NumCh; g++)
  begin : genCheck
    property noOvershoot;
      @(posedge clk) disable iff (rst)
        run[g] |-> count[g] < lenReg[g];
    endproperty
    assert property (noOvershoot)
      else $error("hold timer %0d passed its length", g);
  end

endmodule

/* src/nocArbPkg.sv */
package nocArbPkg;

  // Port count and field widths
  localparam int NumCh   = 5;
  localparam int FlitIdW = 3;
  localparam int LenW    = 12;
  localparam int DataW   = 32;

  // Flit id encodings
  localparam logic [FlitIdW-1:0] FlitHead = 3'd1; // Loads the hold timer
  localparam logic [FlitIdW-1:0] FlitBody = 3'd2;
  localparam logic [FlitIdW-1:0] FlitTail = 3'd3;

  // One bit per channel, bit 0 is L then N, E, W, S
  typedef logic [NumCh-1:0] chanMaskT;

  // Channel position in the rotation
  typedef logic [$clog2(NumCh)-1:0] chanIdxT;

  typedef logic [FlitIdW-1:0] flitIdT;
  typedef logic [LenW-1:0]    lenT;
  typedef logic [DataW-1:0]   dataT;

  // Payload forwarded to the output port
  typedef struct packed {
    flitIdT id;
    dataT   data;
  } flitT;

endpackage

/* src/nocOutPort.sv */
`timescale 1ns/100ps

module nocOutPort (
  input  logic                clk,
  input  logic                rst,
  input  nocArbPkg::chanMaskT req,
  input  nocArbPkg::flitIdT   flitId [nocArbPkg::NumCh],
  input  nocArbPkg::lenT      length [nocArbPkg::NumCh],
  input  nocArbPkg::dataT     data   [nocArbPkg::NumCh],
  output nocArbPkg::chanMaskT grant,
  output nocArbPkg::flitIdT   outFlitId,
  output nocArbPkg::dataT     outData,
  output logic                outValid
);

  import nocArbPkg::*;

  chanMaskT run;
  chanMaskT timesUp;
  flitT     outFlit;

  flitChannel ch (
    .clk (clk)
  );

  // Plain ports into the channel bundle
  assign ch.req = req;

  for (genvar g = 0; g < NumCh; g++)
  begin : genChan
    assign ch.flitId[g] = flitId[g];
    assign ch.length[g] = length[g];
    assign ch.data[g]   = data[g];
  end

  holdTimerBank uTimers (
    .clk     (clk),
    .rst     (rst),
    .ch      (ch.timer),
    .run     (run),
    .timesUp (timesUp)
  );

  grantFsm uGrant (
    .clk     (clk),
    .rst     (rst),
    .ch      (ch.arb),
    .timesUp (timesUp),
    .run     (run),
    .grant   (grant)
  );

  flitSwitch #(
    .payloadT (flitT)
  ) uSwitch (
    .ch       (ch.sw),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  assign outFlitId = outFlit.id;
  assign outData   = outFlit.data;

endmodule
